// File: list.f
+incdir+src
src/hps_pkg.sv
src/hps_frame_fsm.sv
src/word_gather.sv
src/ps2_clk_div.sv
src/ps2_kbd_tx.sv
src/hps_io_lite.sv
verification/hps_io_properties.sv
verification/hps_io_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= hps_io_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/hps_io_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "hps_consts.svh"

module hps_io_tb;

	localparam int WAIT_LIMIT = 3000;

	logic             clk_sys;
	logic             reset;
	logic             io_enable;
	logic             io_strobe;
	hps_pkg::word_t   io_din;
	logic [1:0]       buttons;
	logic             forced_scandoubler;
	hps_pkg::joy_t    joystick_0;
	hps_pkg::joy_t    joystick_1;
	hps_pkg::status_t status;
	logic             ps2_kbd_clk_out;
	logic             ps2_kbd_data_out;

	int               seed;
	int               mismatches;
	int               timeouts;
	// captured PS/2 frames, bit 0 is the start bit
	logic [10:0]      ps2_frames[$];

	hps_io_lite #(.PS2_DIV(4)) u_dut (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ps2_kbd_clk_out    (ps2_kbd_clk_out),
		.ps2_kbd_data_out   (ps2_kbd_data_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// host bus and PS/2 capture
	////////////////////////////////////////////////////////////

	// command word plus up to four data words, an idle cycle after each strobe
	task automatic send_frame(input int n, input hps_pkg::word_t w0,
		input hps_pkg::word_t w1 = '0, input hps_pkg::word_t w2 = '0,
		input hps_pkg::word_t w3 = '0, input hps_pkg::word_t w4 = '0);
		hps_pkg::word_t words [5];
		words = '{w0, w1, w2, w3, w4};
		@(negedge clk_sys);
		io_enable = 1'b1;
		for (int i = 0; i < n; i++) begin
			@(negedge clk_sys);
			io_din    = words[i];
			io_strobe = 1'b1;
			@(negedge clk_sys);
			io_strobe = 1'b0;
		end
		@(negedge clk_sys);
		io_enable = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual == expected) else begin
			mismatches++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// sample the data line on each falling edge of the PS/2 clock
	initial begin : ps2_capture
		logic        prev_clk;
		logic [10:0] bits;
		int          nbits;
		prev_clk = 1'b1;
		bits     = '0;
		nbits    = 0;
		forever begin
			@(negedge clk_sys);
			if (reset) begin
				nbits = 0;
			end else if (prev_clk && !ps2_kbd_clk_out) begin
				bits[nbits] = ps2_kbd_data_out;
				nbits++;
				if (nbits == 11) begin
					ps2_frames.push_back(bits);
					nbits = 0;
				end
			end
			prev_clk = ps2_kbd_clk_out;
		end
	end

	task automatic check_ps2_byte(input string name, input logic [7:0] expected);
		int          cycles;
		logic [10:0] frame;
		cycles = 0;
		while ((ps2_frames.size() == 0) && (cycles < WAIT_LIMIT)) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (ps2_frames.size() == 0) begin
			timeouts++;
			$display("timeout: no PS/2 byte arrived for %s", name);
		end else begin
			frame = ps2_frames.pop_front();
			check_value({name, " start"}, 64'(1'b0), 64'(frame[0]));
			check_value({name, " data"}, 64'(expected), 64'(frame[8:1]));
			// odd parity over data and parity bit
			check_value({name, " parity"}, 64'(~^expected), 64'(frame[9]));
			check_value({name, " stop"}, 64'(1'b1), 64'(frame[10]));
		end
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////

	initial begin : stimulus
		hps_pkg::word_t w [4];
		logic [7:0]     kbd [3];
		seed       = 32'h9d9d_f104;
		mismatches = 0;
		timeouts   = 0;
		reset      = 1'b1;
		io_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		repeat (2) @(negedge clk_sys);
		reset = 1'b0;

		foreach (w[i]) w[i] = hps_pkg::word_t'($random(seed));
		send_frame(2, `CMD_CFG, w[0]);
		check_value("config buttons", 64'(w[0][1:0]), 64'(buttons));
		check_value("config scandoubler", 64'(w[0][4]), 64'(forced_scandoubler));

		// third data word lies past the joystick payload
		send_frame(4, `CMD_JOY0, w[1], w[2], w[3]);
		check_value("joystick 0", 64'({w[2], w[1]}), 64'(joystick_0));

		foreach (w[i]) w[i] = hps_pkg::word_t'($random(seed));
		send_frame(5, `CMD_STATUS, w[0], w[1], w[2], w[3]);
		check_value("status", {w[3], w[2], w[1], w[0]}, status);
		send_frame(3, `CMD_JOY1, w[2], w[0]);
		check_value("joystick 1", 64'({w[0], w[2]}), 64'(joystick_1));
		check_value("status held", {w[3], w[2], w[1], w[0]}, status);

		foreach (kbd[i]) kbd[i] = 8'($random(seed));
		send_frame(4, `CMD_KBD, {1'b0, 7'($random(seed)), kbd[0]},
			{1'b0, 7'($random(seed)), kbd[1]}, {1'b0, 7'($random(seed)), kbd[2]});
		check_ps2_byte("kbd byte 0", kbd[0]);
		check_ps2_byte("kbd byte 1", kbd[1]);
		check_ps2_byte("kbd byte 2", kbd[2]);

		// skip mark in the second data word drops the rest of the frame
		send_frame(4, `CMD_KBD, {8'h00, kbd[1]}, {`PS2_SKIP_MARK, kbd[2]}, {8'h00, ~kbd[1]});
		check_ps2_byte("skip first byte", kbd[1]);
		send_frame(2, `CMD_KBD, {8'h00, kbd[0]});
		check_ps2_byte("after skip", kbd[0]);

		repeat (4) @(negedge clk_sys);
		$display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if ((mismatches == 0) && (timeouts == 0)) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/hps_io_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "hps_consts.svh"

module hps_io_properties (
	input  wire              clk_sys,
	input  wire              reset,
	input  wire              io_enable,
	input  wire              io_strobe,
	input  hps_pkg::word_t   io_din,
	input  wire [1:0]        buttons,
	input  wire              forced_scandoubler,
	input  hps_pkg::joy_t    joystick_0,
	input  hps_pkg::joy_t    joystick_1,
	input  hps_pkg::status_t status,
	input  wire              ps2_kbd_clk_out,
	input  wire              ps2_kbd_data_out,
	input  wire              tx_busy
);

	// host side view of frames, only the config word is kept
	logic [3:0]     word_cnt;
	hps_pkg::word_t frame_cmd;
	logic [1:0]     last_buttons;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			word_cnt     <= '0;
			frame_cmd    <= '0;
			last_buttons <= '0;
		end else if (!io_enable) begin
			word_cnt <= '0;
		end else if (io_strobe) begin
			if (word_cnt == 4'd0) begin
				frame_cmd <= io_din;
			end else if ((word_cnt == 4'd1) && (frame_cmd == `CMD_CFG)) begin
				last_buttons <= io_din[1:0];
			end
			if (word_cnt != 4'hF) begin
				word_cnt <= word_cnt + 4'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// properties
	////////////////////////////////////////////////////////////

	reset_outputs_idle: assert property (@(posedge clk_sys)
		$fell(reset) |-> (buttons == 2'b00) && !forced_scandoubler &&
		(joystick_0 == '0) && (joystick_1 == '0) && (status == '0) &&
		ps2_kbd_clk_out && ps2_kbd_data_out)
		else $error("outputs not idle in the cycle after reset");

	buttons_follow_config: assert property (@(posedge clk_sys) disable iff (reset)
		buttons == last_buttons)
		else $error("buttons differ from the last config word");

	// no clock pulses outside a byte
	clk_idle_high: assert property (@(posedge clk_sys) disable iff (reset)
		!tx_busy |-> ps2_kbd_clk_out)
		else $error("PS/2 clock low while the transmitter is idle");

	data_moves_on_clk_high: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(ps2_kbd_data_out) |-> ps2_kbd_clk_out)
		else $error("PS/2 data changed while the PS/2 clock was low");

endmodule

bind hps_io_lite hps_io_properties u_props (
	.clk_sys            (clk_sys),
	.reset              (reset),
	.io_enable          (io_enable),
	.io_strobe          (io_strobe),
	.io_din             (io_din),
	.buttons            (buttons),
	.forced_scandoubler (forced_scandoubler),
	.joystick_0         (joystick_0),
	.joystick_1         (joystick_1),
	.status             (status),
	.ps2_kbd_clk_out    (ps2_kbd_clk_out),
	.ps2_kbd_data_out   (ps2_kbd_data_out),
	.tx_busy            (u_ps2_kbd_tx.tx_busy)
);

`default_nettype wire

// File: src/hps_io_lite.sv
`timescale 1ns/1ps
`default_nettype none

module hps_io_lite #(
	parameter int PS2_DIV = 4
) (
	input  wire              clk_sys,
	input  wire              reset,
	input  wire              io_enable,
	input  wire              io_strobe,
	input  hps_pkg::word_t   io_din,
	output logic [1:0]       buttons,
	output logic             forced_scandoubler,
	output hps_pkg::joy_t    joystick_0,
	output hps_pkg::joy_t    joystick_1,
	output hps_pkg::status_t status,
	output logic             ps2_kbd_clk_out,
	output logic             ps2_kbd_data_out
);

	hps_pkg::cmd_t      cmd;
	hps_pkg::word_idx_t word_idx;
	logic               data_stb;
	logic               kbd_push;
	hps_pkg::kbd_byte_t kbd_byte;
	hps_pkg::cfg_t      cfg;
	logic               bit_rise;
	logic               bit_fall;

	// one compare per gathered register
	logic sel_cfg;
	logic sel_joy0;
	logic sel_joy1;
	logic sel_status;

	assign sel_cfg    = (cmd == hps_pkg::cmd_cfg);
	assign sel_joy0   = (cmd == hps_pkg::cmd_joy0);
	assign sel_joy1   = (cmd == hps_pkg::cmd_joy1);
	assign sel_status = (cmd == hps_pkg::cmd_status);

	// config bits seen by the core
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];

	////////////////////////////////////////////////////////////
	// host command framing
	////////////////////////////////////////////////////////////

	hps_frame_fsm u_frame_fsm (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_enable (io_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.cmd       (cmd),
		.word_idx  (word_idx),
		.data_stb  (data_stb),
		.kbd_push  (kbd_push),
		.kbd_byte  (kbd_byte)
	);

	word_gather #(.payload_t(hps_pkg::cfg_t)) u_cfg_gather (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.sel      (sel_cfg),
		.data_stb (data_stb),
		.word_idx (word_idx),
		.io_din   (io_din),
		.payload  (cfg)
	);

	word_gather #(.payload_t(hps_pkg::joy_t)) u_joy0_gather (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.sel      (sel_joy0),
		.data_stb (data_stb),
		.word_idx (word_idx),
		.io_din   (io_din),
		.payload  (joystick_0)
	);

	word_gather #(.payload_t(hps_pkg::joy_t)) u_joy1_gather (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.sel      (sel_joy1),
		.data_stb (data_stb),
		.word_idx (word_idx),
		.io_din   (io_din),
		.payload  (joystick_1)
	);

	word_gather #(.payload_t(hps_pkg::status_t)) u_status_gather (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.sel      (sel_status),
		.data_stb (data_stb),
		.word_idx (word_idx),
		.io_din   (io_din),
		.payload  (status)
	);

	////////////////////////////////////////////////////////////
	// PS/2 keyboard output
	////////////////////////////////////////////////////////////

	ps2_clk_div #(.PS2_DIV(PS2_DIV)) u_ps2_clk_div (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bit_rise (bit_rise),
		.bit_fall (bit_fall)
	);

	ps2_kbd_tx u_ps2_kbd_tx (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.bit_rise         (bit_rise),
		.bit_fall         (bit_fall),
		.kbd_push         (kbd_push),
		.kbd_byte         (kbd_byte),
		.ps2_kbd_clk_out  (ps2_kbd_clk_out),
		.ps2_kbd_data_out (ps2_kbd_data_out)
	);

endmodule

`default_nettype wire

// File: src/ps2_kbd_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "hps_consts.svh"

module ps2_kbd_tx (
	input  wire                clk_sys,
	input  wire                reset,
	input  wire                bit_rise,
	input  wire                bit_fall,
	input  wire                kbd_push,
	input  hps_pkg::kbd_byte_t kbd_byte,
	output logic               ps2_kbd_clk_out,
	output logic               ps2_kbd_data_out
);

	localparam int FIFO_BITS  = `KBD_FIFO_BITS;
	localparam int FIFO_DEPTH = 1 << FIFO_BITS;
	localparam int HOLD_W     = $clog2(`PS2_TX_HOLDOFF + 1);

	////////////////////////////////////////////////////////////
	// byte FIFO
	////////////////////////////////////////////////////////////

	hps_pkg::kbd_byte_t fifo_mem [FIFO_DEPTH];

	// one extra pointer bit tells full from empty
	logic [FIFO_BITS:0] wptr;
	logic [FIFO_BITS:0] rptr;
	logic               fifo_empty;
	logic               fifo_full;
	logic               fifo_wr;
	logic               fifo_rd;

	assign fifo_empty = (wptr == rptr);
	assign fifo_full  = (wptr[FIFO_BITS] != rptr[FIFO_BITS]) &&
		(wptr[FIFO_BITS-1:0] == rptr[FIFO_BITS-1:0]);

	// bytes pushed into a full FIFO are lost
	assign fifo_wr = kbd_push && !fifo_full;

	always_ff @(posedge clk_sys) begin
		if (fifo_wr) begin
			fifo_mem[wptr[FIFO_BITS-1:0]] <= kbd_byte;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wptr <= '0;
		end else if (fifo_wr) begin
			wptr <= wptr + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// serial transmitter
	////////////////////////////////////////////////////////////

	// 0 idle, 1..8 data bits, 9 parity, 10 stop, 11 last clock low
	logic [3:0]         tx_state;
	logic [HOLD_W-1:0]  holdoff;
	hps_pkg::kbd_byte_t tx_byte;
	logic               parity;
	logic               tx_busy;

	assign tx_busy = (tx_state != 4'd0);

	// pop once the holdoff count has run out on a rising edge
	assign fifo_rd = bit_rise && !tx_busy && !fifo_empty &&
		(holdoff == HOLD_W'(`PS2_TX_HOLDOFF));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rptr <= '0;
		end else if (fifo_rd) begin
			rptr <= rptr + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tx_state         <= 4'd0;
			holdoff          <= '0;
			ps2_kbd_data_out <= 1'b1;
		end else if (bit_rise) begin
			if (!tx_busy) begin
				if (fifo_rd) begin
					tx_byte          <= fifo_mem[rptr[FIFO_BITS-1:0]];
					holdoff          <= '0;
					parity           <= 1'b1;
					tx_state         <= 4'd1;
					// start bit
					ps2_kbd_data_out <= 1'b0;
				end else if (!fifo_empty) begin
					holdoff <= holdoff + HOLD_W'(1);
				end
			end else begin
				if (tx_state <= 4'd8) begin
					// data bits LSB first
					ps2_kbd_data_out <= tx_byte[0];
					tx_byte          <= {1'b0, tx_byte[7:1]};
					parity           <= parity ^ tx_byte[0];
				end else if (tx_state == 4'd9) begin
					ps2_kbd_data_out <= parity;
				end else if (tx_state == 4'd10) begin
					ps2_kbd_data_out <= 1'b1;
				end
				tx_state <= (tx_state == 4'd11) ? 4'd0 : tx_state + 4'd1;
			end
		end
	end

	// clock pulses low only while a byte is on the line
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ps2_kbd_clk_out <= 1'b1;
		end else if (bit_rise) begin
			ps2_kbd_clk_out <= 1'b1;
		end else if (bit_fall) begin
			ps2_kbd_clk_out <= !tx_busy;
		end
	end

endmodule

`default_nettype wire

// File: src/ps2_clk_div.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_clk_div #(
	parameter int PS2_DIV = 4
) (
	input  wire  clk_sys,
	input  wire  reset,
	output logic bit_rise,
	output logic bit_fall
);

	localparam int CNT_W = (PS2_DIV > 1) ? $clog2(PS2_DIV) : 1;

	logic [CNT_W-1:0] cnt;
	logic             clk_ps2;

	// toggle every PS2_DIV cycles, so one PS/2 period is 2*PS2_DIV
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cnt      <= '0;
			clk_ps2  <= 1'b0;
			bit_rise <= 1'b0;
			bit_fall <= 1'b0;
		end else begin
			bit_rise <= 1'b0;
			bit_fall <= 1'b0;
			if (cnt == CNT_W'(PS2_DIV - 1)) begin
				cnt      <= '0;
				clk_ps2  <= ~clk_ps2;
				// one pulse per edge of the divided clock
				bit_rise <= ~clk_ps2;
				bit_fall <= clk_ps2;
			end else begin
				cnt <= cnt + CNT_W'(1);
			end
		end
	end

endmodule

`default_nettype wire

// File: src/word_gather.sv
`timescale 1ns/1ps
`default_nettype none

`include "hps_consts.svh"

module word_gather #(
	parameter type payload_t = hps_pkg::cfg_t
) (
	input  wire                clk_sys,
	input  wire                reset,
	input  wire                sel,
	input  wire                data_stb,
	input  hps_pkg::word_idx_t word_idx,
	input  hps_pkg::word_t     io_din,
	output payload_t           payload
);

	localparam int PAYLOAD_W = $bits(payload_t);

	// number of host words that fill the payload
	localparam int N_WORDS = PAYLOAD_W / `WORD_W;

	logic load;

	assign load = sel && data_stb;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			payload <= '0;
		end else if (load) begin
			// word n goes into slice n-1, lowest half first
			for (int i = 0; i < N_WORDS; i++) begin
				if (word_idx == hps_pkg::word_idx_t'(i + 1)) begin
					payload[i*`WORD_W +: `WORD_W] <= io_din;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: src/hps_frame_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "hps_consts.svh"

module hps_frame_fsm (
	input  wire               clk_sys,
	input  wire               reset,
	input  wire               io_enable,
	input  wire               io_strobe,
	input  hps_pkg::word_t    io_din,
	output hps_pkg::cmd_t     cmd,
	output hps_pkg::word_idx_t word_idx,
	output logic              data_stb,
	output logic              kbd_push,
	output hps_pkg::kbd_byte_t kbd_byte
);

	typedef enum logic [1:0] {
		st_idle,
		st_cmd,
		st_data
	} state_t;

	state_t state;
	logic   skip;
	logic   word_strobe;
	logic   skip_word;

	////////////////////////////////////////////////////////////
	// strobe decode
	////////////////////////////////////////////////////////////

	assign word_strobe = io_enable && io_strobe;

	// data words go straight out so the gathered value lands one cycle later
	assign data_stb = word_strobe && (state == st_data);

	// skip mark in the high byte of a keyboard word
	assign skip_word = (io_din[15:8] == `PS2_SKIP_MARK);

	assign kbd_push = data_stb && (cmd == hps_pkg::cmd_kbd) && !skip && !skip_word;
	assign kbd_byte = io_din[7:0];

	////////////////////////////////////////////////////////////
	// frame state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= st_idle;
			cmd      <= hps_pkg::cmd_none;
			word_idx <= '0;
			skip     <= 1'b0;
		end else if (!io_enable) begin
			// frame over, wait for the next one
			state    <= st_idle;
			cmd      <= hps_pkg::cmd_none;
			word_idx <= '0;
			skip     <= 1'b0;
		end else begin
			case (state)
				st_idle, st_cmd: begin
					if (io_strobe) begin
						// first word of the frame is the command
						cmd      <= hps_pkg::cmd_t'(io_din);
						word_idx <= hps_pkg::word_idx_t'(1);
						state    <= st_data;
					end else begin
						state <= st_cmd;
					end
				end
				st_data: begin
					if (io_strobe) begin
						// saturate so long frames never wrap onto a low slice
						if (word_idx != '1) begin
							word_idx <= word_idx + hps_pkg::word_idx_t'(1);
						end
						if ((cmd == hps_pkg::cmd_kbd) && skip_word) begin
							skip <= 1'b1;
						end
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/hps_pkg.sv
`default_nettype none

`include "hps_consts.svh"

package hps_pkg;

	// one word on the host command bus
	typedef logic [`WORD_W-1:0] word_t;

	// command codes; cmd_none is the value held between frames
	typedef enum logic [`WORD_W-1:0] {
		cmd_none   = 16'h0000,
		cmd_cfg    = `CMD_CFG,
		cmd_joy0   = `CMD_JOY0,
		cmd_joy1   = `CMD_JOY1,
		cmd_kbd    = `CMD_KBD,
		cmd_status = `CMD_STATUS
	} cmd_t;

	// payloads assembled from host words
	typedef logic [15:0] cfg_t;
	typedef logic [31:0] joy_t;
	typedef logic [63:0] status_t;

	typedef logic [7:0] kbd_byte_t;

	// data word position in a frame, first data word is 1
	typedef logic [3:0] word_idx_t;

endpackage

`default_nettype wire

// File: src/hps_consts.svh
`ifndef HPS_CONSTS_SVH
`define HPS_CONSTS_SVH

// host command codes kept by the bridge
`define CMD_CFG        16'h0001
`define CMD_JOY0       16'h0002
`define CMD_JOY1       16'h0003
`define CMD_KBD        16'h0005
`define CMD_STATUS     16'h001E

// host bus word width
`define WORD_W         16

// keyboard FIFO depth is 2**KBD_FIFO_BITS bytes
`define KBD_FIFO_BITS  5

// idle PS/2 bit clocks counted before a byte starts
`define PS2_TX_HOLDOFF 4

// high byte of a keyboard data word that ends the frame early
`define PS2_SKIP_MARK  8'hFF

`endif
